//--- dv/router_tb_util.svh
`ifndef ROUTER_TB_UTIL_SVH
`define ROUTER_TB_UTIL_SVH

////////////////////////////////////////
// packet kinds and expected outputs
////////////////////////////////////////

localparam int KIND_DATA  = 0;
localparam int KIND_NOUDP = 1;
localparam int KIND_ZVRT  = 2;

localparam int OUT_DSP  = 0;
localparam int OUT_SER  = 1;
localparam int OUT_BOTH = 2;

localparam logic [15:0] LFSR_SEED = 16'd88;

// 16-bit fibonacci lfsr, taps 16 14 13 11, new bit enters at bit 0
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

// err_count lives in the including module
task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        $display("Error: time %0t, %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        err_count++;
    end
endtask

////////////////////////////////////////
// packet builder
////////////////////////////////////////

// ascending payload with the row tag on top, header fields laid over it
function automatic line_t build_line(input int kind, input int len, input logic [31:0] dst_ip,
                                     input int tag, input int idx);
    line_t l;
    l = '0;
    l[DATA_W-1:0] = {8'(tag), 8'h5a, 16'(idx)};
    case (idx)
        ETHTYPE_LINE: begin
            l[15:0] = ETHTYPE_IPV4;
        end
        PROTO_LINE: begin
            l[23:16] = (kind == KIND_NOUDP) ? 8'h06 : PROTO_UDP;
        end
        DST_IP_LINE: begin
            l[DATA_W-1:0] = dst_ip;
        end
        UDP_PORT_LINE: begin
            l[15:0] = UDP_DATA_PORT;
        end
        int'(DSP_OFFSET): begin
            // vrt header word
            if (kind == KIND_ZVRT) begin
                l[DATA_W-1:0] = '0;
            end
        end
        default: begin
        end
    endcase
    l[SOF_BIT] = (idx == 0);
    l[EOF_BIT] = (idx == len - 1);
    return l;
endfunction

`endif

//--- dv/tb_packet_router.sv
module tb_packet_router
    import router_stream_pkg::*;
    import router_proto_pkg::*;
;

    localparam int          CLK_PERIOD = 40;
    localparam int          DRIVE_DLY  = 5;
    localparam int          NUM_ROWS   = 11;
    localparam int          WDOG_CYCLES = NUM_ROWS * 200 + 100;
    localparam logic [31:0] MY_IP    = 32'hc0a8_0a05;
    localparam logic [31:0] OTHER_IP = 32'hc0a8_0a77;

    typedef struct packed {
        int          kind;
        int          len;
        logic [31:0] dst_ip;
        int          exp_out;
        logic        bp;
        logic        bad_wr;
    } row_t;

    logic stream_clk;
    logic rst_n_i;
    logic set_stb;
    logic [7:0] set_addr;
    logic [31:0] set_data;
    line_t com_inp_data;
    logic com_inp_valid;
    logic com_inp_ready;
    line_t dsp_data, ser_data, cpu_data;
    logic dsp_valid, ser_valid, cpu_valid;
    logic dsp_ready, ser_ready, cpu_ready;

    int err_count;
    int rows_ok;
    int rows_bad;
    int dsp_eofs, ser_eofs, cpu_eofs;
    logic bp_on;
    logic [15:0] lfsr;
    row_t rows [NUM_ROWS];
    line_t dsp_q[$], ser_q[$], cpu_q[$];
    line_t exp_dsp[$], exp_ser[$], exp_cpu[$];

    `include "router_tb_util.svh"

    packet_router_top dut_i (
        .stream_clk(stream_clk), .rst_n_i(rst_n_i),
        .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
        .com_inp_data_i(com_inp_data), .com_inp_valid_i(com_inp_valid),
        .com_inp_ready_o(com_inp_ready),
        .dsp_out_data_o(dsp_data), .dsp_out_valid_o(dsp_valid), .dsp_out_ready_i(dsp_ready),
        .ser_out_data_o(ser_data), .ser_out_valid_o(ser_valid), .ser_out_ready_i(ser_ready),
        .cpu_out_data_o(cpu_data), .cpu_out_valid_o(cpu_valid), .cpu_out_ready_i(cpu_ready)
    );

    initial begin
        stream_clk = 1'b0;
        forever #(CLK_PERIOD / 2) stream_clk = ~stream_clk;
    end

    // output readies go random in back-pressure rows
    initial begin
        dsp_ready = 1'b1;
        ser_ready = 1'b1;
        cpu_ready = 1'b1;
        lfsr = LFSR_SEED;
        forever begin
            @(posedge stream_clk);
            #DRIVE_DLY;
            if (bp_on) begin
                lfsr = lfsr_step(lfsr);
                dsp_ready = lfsr[0];
                lfsr = lfsr_step(lfsr);
                ser_ready = lfsr[0];
                lfsr = lfsr_step(lfsr);
                cpu_ready = lfsr[0];
            end else begin
                dsp_ready = 1'b1;
                ser_ready = 1'b1;
                cpu_ready = 1'b1;
            end
        end
    end

    // lines that transfer on the next rising edge are recorded at the falling edge
    always @(negedge stream_clk) begin
        if (dsp_valid && dsp_ready) begin
            dsp_q.push_back(dsp_data);
            if (dsp_data[EOF_BIT]) dsp_eofs++;
        end
        if (ser_valid && ser_ready) begin
            ser_q.push_back(ser_data);
            if (ser_data[EOF_BIT]) ser_eofs++;
        end
        if (cpu_valid && cpu_ready) begin
            cpu_q.push_back(cpu_data);
            if (cpu_data[EOF_BIT]) cpu_eofs++;
        end
    end

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("Error: watchdog expired, the run did not finish in %0d cycles", WDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    task automatic load_table();
        rows[0]  = '{KIND_DATA,  20, MY_IP,    OUT_DSP,  1'b0, 1'b0};
        rows[1]  = '{KIND_DATA,  20, OTHER_IP, OUT_SER,  1'b0, 1'b0};
        rows[2]  = '{KIND_DATA,   6, MY_IP,    OUT_BOTH, 1'b0, 1'b0};
        rows[3]  = '{KIND_NOUDP, 16, MY_IP,    OUT_BOTH, 1'b0, 1'b0};
        rows[4]  = '{KIND_ZVRT,  20, MY_IP,    OUT_BOTH, 1'b0, 1'b0};
        rows[5]  = '{KIND_DATA,  20, MY_IP,    OUT_DSP,  1'b1, 1'b0};
        rows[6]  = '{KIND_DATA,  20, OTHER_IP, OUT_SER,  1'b1, 1'b0};
        rows[7]  = '{KIND_DATA,   6, MY_IP,    OUT_BOTH, 1'b1, 1'b0};
        rows[8]  = '{KIND_NOUDP, 16, MY_IP,    OUT_BOTH, 1'b1, 1'b0};
        rows[9]  = '{KIND_ZVRT,  20, MY_IP,    OUT_BOTH, 1'b1, 1'b0};
        // a write to another address comes first and must leave the ip alone
        rows[10] = '{KIND_DATA,  14, MY_IP,    OUT_DSP,  1'b0, 1'b1};
    endtask

    task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
        set_addr = addr;
        set_data = data;
        set_stb = 1'b1;
        @(posedge stream_clk);
        #DRIVE_DLY;
        set_stb = 1'b0;
    endtask

    task automatic send_line(input line_t l);
        logic taken;
        com_inp_data = l;
        com_inp_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge stream_clk);
            taken = com_inp_ready;
            @(posedge stream_clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic send_packet(input int r);
        for (int k = 0; k < rows[r].len; k++) begin
            send_line(build_line(rows[r].kind, rows[r].len, rows[r].dst_ip, r, k));
        end
        com_inp_valid = 1'b0;
    endtask

    // dsp gets the vrt line onwards with fresh flags while the other paths get the whole packet
    task automatic build_expected(input int r);
        line_t l;
        for (int k = 0; k < rows[r].len; k++) begin
            l = build_line(rows[r].kind, rows[r].len, rows[r].dst_ip, r, k);
            if (rows[r].exp_out == OUT_DSP) begin
                if (k == int'(DSP_OFFSET)) begin
                    l[LINE_W-1:DATA_W] = '0;
                    l[SOF_BIT] = 1'b1;
                    l[EOF_BIT] = (k == rows[r].len - 1);
                end
                if (k >= int'(DSP_OFFSET)) exp_dsp.push_back(l);
            end else begin
                exp_ser.push_back(l);
                if (rows[r].exp_out == OUT_BOTH) exp_cpu.push_back(l);
            end
        end
    endtask

    task automatic compare_queue(input string name, input line_t got[$], input line_t exp[$]);
        check_value({name, " line count"}, 64'(got.size()), 64'(exp.size()));
        for (int k = 0; k < exp.size() && k < got.size(); k++) begin
            check_value($sformatf("%s line %0d", name, k), 64'(got[k]), 64'(exp[k]));
        end
    endtask

    function automatic string out_name(input int o);
        case (o)
            OUT_DSP: return "dsp";
            OUT_SER: return "ser";
            default: return "ser+cpu";
        endcase
    endfunction

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int errs_before;
        int want_dsp, want_ser, want_cpu;
        rst_n_i = 1'b0;
        set_stb = 1'b0;
        set_addr = '0;
        set_data = '0;
        com_inp_data = '0;
        com_inp_valid = 1'b0;
        bp_on = 1'b0;
        err_count = 0;
        rows_ok = 0;
        rows_bad = 0;
        dsp_eofs = 0;
        ser_eofs = 0;
        cpu_eofs = 0;
        load_table();

        repeat (16) @(posedge stream_clk);
        #DRIVE_DLY;
        rst_n_i = 1'b1;
        @(posedge stream_clk);
        #DRIVE_DLY;
        check_value("dsp_out_valid after reset", 64'(dsp_valid), 64'd0);
        check_value("ser_out_valid after reset", 64'(ser_valid), 64'd0);
        check_value("cpu_out_valid after reset", 64'(cpu_valid), 64'd0);
        check_value("com_inp_ready after reset", 64'(com_inp_ready), 64'd1);

        // program the low half and then the high half
        write_setting(CTRL_ADDR, {MY_IP[15:0], 10'd0, IP_SEL_LO, 4'd0});
        write_setting(CTRL_ADDR, {MY_IP[31:16], 10'd0, IP_SEL_HI, 4'd0});
        @(posedge stream_clk);

        for (int i = 0; i < NUM_ROWS; i++) begin
            errs_before = err_count;
            bp_on = rows[i].bp;
            build_expected(i);
            want_dsp = dsp_eofs + ((rows[i].exp_out == OUT_DSP) ? 1 : 0);
            want_ser = ser_eofs + ((rows[i].exp_out != OUT_DSP) ? 1 : 0);
            want_cpu = cpu_eofs + ((rows[i].exp_out == OUT_BOTH) ? 1 : 0);
            #DRIVE_DLY;
            if (rows[i].bad_wr) begin
                write_setting(8'd3, {16'hdead, 10'd0, IP_SEL_HI, 4'd0});
            end
            send_packet(i);
            while (dsp_eofs < want_dsp || ser_eofs < want_ser || cpu_eofs < want_cpu) begin
                @(posedge stream_clk);
            end
            @(posedge stream_clk);

            compare_queue("dsp_out", dsp_q, exp_dsp);
            compare_queue("ser_out", ser_q, exp_ser);
            compare_queue("cpu_out", cpu_q, exp_cpu);
            dsp_q.delete();
            ser_q.delete();
            cpu_q.delete();
            exp_dsp.delete();
            exp_ser.delete();
            exp_cpu.delete();

            if (err_count == errs_before) begin
                rows_ok++;
                $display("row %0d: %0d lines to %s, back-pressure %0d, ok",
                         i, rows[i].len, out_name(rows[i].exp_out), rows[i].bp);
            end else begin
                rows_bad++;
                $display("row %0d: %0d lines to %s, back-pressure %0d, FAILED",
                         i, rows[i].len, out_name(rows[i].exp_out), rows[i].bp);
            end
        end

        // late lines on any output would land here
        bp_on = 1'b0;
        repeat (20) @(posedge stream_clk);
        check_value("dsp_out lines after last row", 64'(dsp_q.size()), 64'd0);
        check_value("ser_out lines after last row", 64'(ser_q.size()), 64'd0);
        check_value("cpu_out lines after last row", 64'(cpu_q.size()), 64'd0);

        $display("rows run %0d, ok %0d, failed %0d, mismatches %0d",
                 NUM_ROWS, rows_ok, rows_bad, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- hw/com_inspector.sv
module com_inspector
    import router_stream_pkg::*;
    import router_proto_pkg::*;
(
    input  logic              stream_clk,
    input  logic              rst_n_i,
    input  logic [DATA_W-1:0] my_ip_i,

    // packets from the communication input
    input  line_t             inp_data_i,
    input  logic              inp_valid_i,
    output logic              inp_ready_o,

    // fast path to this router's dsp
    output line_t             fp_this_data_o,
    output logic              fp_this_valid_o,
    input  logic              fp_this_ready_i,

    // fast path on towards another router
    output line_t             fp_other_data_o,
    output logic              fp_other_valid_o,
    input  logic              fp_other_ready_i,

    // slow path, serdes and cpu both get a copy
    output line_t             sp_both_data_o,
    output logic              sp_both_valid_o,
    input  logic              sp_both_ready_i
);

    typedef enum logic [1:0] {
        ST_WAIT_SOF,
        ST_READ,
        ST_WRITE_REGS,
        ST_WRITE_LIVE
    } state_t;

    state_t    state_q;
    dest_t     dest_q;
    dreg_idx_t idx_q;
    line_t     dregs [NUM_DREGS];

    logic                 inp_xfer;
    logic                 buf_wr;
    logic                 last_hdr;
    logic                 hdr_is_data;
    logic                 ip_match;
    line_t                replay_line;
    logic [LINE_W-DATA_W-1:0] replay_flags;
    line_t                out_data;
    logic                 out_valid;
    logic                 out_ready;
    logic                 out_xfer;

    ////////////////////////////////////////
    // classification
    ////////////////////////////////////////

    // evaluated while the vrt header line (line 11) sits on the input
    assign hdr_is_data = (dregs[ETHTYPE_LINE][15:0] == ETHTYPE_IPV4)
                      && (dregs[PROTO_LINE][23:16] == PROTO_UDP)
                      && (dregs[UDP_PORT_LINE][15:0] == UDP_DATA_PORT)
                      && (inp_data_i[DATA_W-1:0] != '0);
    assign ip_match    = (dregs[DST_IP_LINE][DATA_W-1:0] == my_ip_i);
    assign last_hdr    = (idx_q == dreg_idx_t'(NUM_DREGS - 1));

    ////////////////////////////////////////
    // output steering
    ////////////////////////////////////////

    assign replay_line = dregs[idx_q];

    // the dsp sees a fresh frame starting at the vrt header; eof is kept
    // so a packet that ends on that line still closes on the dsp side
    always_comb begin
        replay_flags = replay_line[LINE_W-1:DATA_W];
        if (dest_q == DEST_FP_THIS && idx_q == DSP_OFFSET) begin
            replay_flags = '0;
            replay_flags[SOF_BIT-DATA_W] = 1'b1;
            replay_flags[EOF_BIT-DATA_W] = replay_line[EOF_BIT];
        end
    end

    assign out_data  = (state_q == ST_WRITE_REGS) ?
                       {replay_flags, replay_line[DATA_W-1:0]} : inp_data_i;
    assign out_valid = (state_q == ST_WRITE_REGS) ||
                       (state_q == ST_WRITE_LIVE && inp_valid_i);

    always_comb begin
        case (dest_q)
            DEST_FP_THIS:  out_ready = fp_this_ready_i;
            DEST_FP_OTHER: out_ready = fp_other_ready_i;
            DEST_SP_BOTH:  out_ready = sp_both_ready_i;
            default:       out_ready = 1'b0;
        endcase
    end

    assign out_xfer = out_valid && out_ready;

    // data is shared, only the chosen destination sees valid
    assign fp_this_data_o   = out_data;
    assign fp_other_data_o  = out_data;
    assign sp_both_data_o   = out_data;
    assign fp_this_valid_o  = out_valid && (dest_q == DEST_FP_THIS);
    assign fp_other_valid_o = out_valid && (dest_q == DEST_FP_OTHER);
    assign sp_both_valid_o  = out_valid && (dest_q == DEST_SP_BOTH);

    assign inp_ready_o = (state_q == ST_WAIT_SOF || state_q == ST_READ) ? 1'b1 :
                         (state_q == ST_WRITE_LIVE) ? out_ready : 1'b0;
    assign inp_xfer    = inp_valid_i && inp_ready_o;

    ////////////////////////////////////////
    // header buffer
    ////////////////////////////////////////

    assign buf_wr = inp_xfer && ((state_q == ST_WAIT_SOF && inp_data_i[SOF_BIT]) ||
                                 state_q == ST_READ);

    always_ff @(posedge stream_clk) begin
        if (buf_wr) begin
            dregs[idx_q] <= inp_data_i;
        end
    end

    ////////////////////////////////////////
    // inspector FSM
    ////////////////////////////////////////

    always_ff @(posedge stream_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_WAIT_SOF;
            dest_q  <= DEST_SP_BOTH;
            idx_q   <= '0;
        end else begin
            case (state_q)
                ST_WAIT_SOF: begin
                    // lines outside a frame are dropped here
                    if (inp_xfer && inp_data_i[SOF_BIT]) begin
                        if (inp_data_i[EOF_BIT]) begin
                            dest_q  <= DEST_SP_BOTH;
                            state_q <= ST_WRITE_REGS;
                        end else begin
                            state_q <= ST_READ;
                            idx_q   <= dreg_idx_t'(1);
                        end
                    end
                end
                ST_READ: begin
                    if (inp_xfer) begin
                        if (last_hdr && hdr_is_data && ip_match) begin
                            dest_q  <= DEST_FP_THIS;
                            state_q <= ST_WRITE_REGS;
                            idx_q   <= DSP_OFFSET;
                        end else if (last_hdr && hdr_is_data) begin
                            dest_q  <= DEST_FP_OTHER;
                            state_q <= ST_WRITE_REGS;
                            idx_q   <= '0;
                        end else if (last_hdr || inp_data_i[EOF_BIT]) begin
                            dest_q  <= DEST_SP_BOTH;
                            state_q <= ST_WRITE_REGS;
                            idx_q   <= '0;
                        end else begin
                            idx_q <= idx_q + dreg_idx_t'(1);
                        end
                    end
                end
                ST_WRITE_REGS: begin
                    if (out_xfer) begin
                        if (replay_line[EOF_BIT]) begin
                            state_q <= ST_WAIT_SOF;
                            idx_q   <= '0;
                        end else if (last_hdr) begin
                            state_q <= ST_WRITE_LIVE;
                            idx_q   <= '0;
                        end else begin
                            idx_q <= idx_q + dreg_idx_t'(1);
                        end
                    end
                end
                ST_WRITE_LIVE: begin
                    if (out_xfer && inp_data_i[EOF_BIT]) begin
                        state_q <= ST_WAIT_SOF;
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/packet_router_top.sv
module packet_router_top
    import router_stream_pkg::*;
    import router_proto_pkg::*;
(
    input  logic                         stream_clk,
    input  logic                         rst_n_i,

    // setting register strobe
    input  logic                         set_stb_i,
    input  logic [$bits(CTRL_ADDR)-1:0]  set_addr_i,
    input  logic [DATA_W-1:0]            set_data_i,

    // communication input
    input  line_t                        com_inp_data_i,
    input  logic                         com_inp_valid_i,
    output logic                         com_inp_ready_o,

    // router outputs
    output line_t                        dsp_out_data_o,
    output logic                         dsp_out_valid_o,
    input  logic                         dsp_out_ready_i,
    output line_t                        ser_out_data_o,
    output logic                         ser_out_valid_o,
    input  logic                         ser_out_ready_i,
    output line_t                        cpu_out_data_o,
    output logic                         cpu_out_valid_o,
    input  logic                         cpu_out_ready_i
);

    logic [DATA_W-1:0] my_ip;

    // inspector to serdes mux and splitter
    line_t fp_other_data;
    logic  fp_other_valid;
    logic  fp_other_ready;
    line_t sp_both_data;
    logic  sp_both_valid;
    logic  sp_both_ready;

    // serdes copy of the slow path
    line_t sp_ser_data;
    logic  sp_ser_valid;
    logic  sp_ser_ready;

    router_settings u_settings (
        .stream_clk(stream_clk), .rst_n_i(rst_n_i),
        .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
        .my_ip_o(my_ip)
    );

    ////////////////////////////////////////
    // inspector and output paths
    ////////////////////////////////////////

    com_inspector u_inspector (
        .stream_clk(stream_clk), .rst_n_i(rst_n_i), .my_ip_i(my_ip),
        .inp_data_i(com_inp_data_i), .inp_valid_i(com_inp_valid_i),
        .inp_ready_o(com_inp_ready_o),
        .fp_this_data_o(dsp_out_data_o), .fp_this_valid_o(dsp_out_valid_o),
        .fp_this_ready_i(dsp_out_ready_i),
        .fp_other_data_o(fp_other_data), .fp_other_valid_o(fp_other_valid),
        .fp_other_ready_i(fp_other_ready),
        .sp_both_data_o(sp_both_data), .sp_both_valid_o(sp_both_valid),
        .sp_both_ready_i(sp_both_ready)
    );

    stream_splitter u_splitter (
        .stream_clk(stream_clk), .rst_n_i(rst_n_i),
        .inp_data_i(sp_both_data), .inp_valid_i(sp_both_valid), .inp_ready_o(sp_both_ready),
        .out0_data_o(sp_ser_data), .out0_valid_o(sp_ser_valid), .out0_ready_i(sp_ser_ready),
        .out1_data_o(cpu_out_data_o), .out1_valid_o(cpu_out_valid_o),
        .out1_ready_i(cpu_out_ready_i)
    );

    // fast path other on input 0, slow path copy on input 1
    stream_mux u_ser_mux (
        .stream_clk(stream_clk), .rst_n_i(rst_n_i),
        .in0_data_i(fp_other_data), .in0_valid_i(fp_other_valid), .in0_ready_o(fp_other_ready),
        .in1_data_i(sp_ser_data), .in1_valid_i(sp_ser_valid), .in1_ready_o(sp_ser_ready),
        .out_data_o(ser_out_data_o), .out_valid_o(ser_out_valid_o),
        .out_ready_i(ser_out_ready_i)
    );

endmodule

//--- hw/router_proto_pkg.sv
package router_proto_pkg;

    ////////////////////////////////////////
    // header buffer
    ////////////////////////////////////////

    // index into the inspector header buffer
    typedef logic [3:0] dreg_idx_t;

    // padded ethernet + ip + udp + vrt header line
    localparam int NUM_DREGS = 12;

    // first line that belongs to the dsp, the vrt header
    localparam dreg_idx_t DSP_OFFSET = 4'd11;

    ////////////////////////////////////////
    // header fields checked by the inspector
    ////////////////////////////////////////

    // ethertype in the low half-word
    localparam int          ETHTYPE_LINE = 3;
    localparam logic [15:0] ETHTYPE_IPV4 = 16'h0800;

    // ip protocol in bits 23 to 16
    localparam int          PROTO_LINE = 6;
    localparam logic [7:0]  PROTO_UDP  = 8'h11;

    // destination ip, whole word
    localparam int          DST_IP_LINE = 8;

    // udp destination port in the low half-word
    localparam int          UDP_PORT_LINE = 9;
    localparam logic [15:0] UDP_DATA_PORT = 16'd49153;

    ////////////////////////////////////////
    // setting register
    ////////////////////////////////////////

    localparam logic [7:0] CTRL_ADDR = 8'd0;

    // control bits 5:4 pick which ip half the upper data half-word goes to
    localparam logic [1:0] IP_SEL_LO = 2'd1;
    localparam logic [1:0] IP_SEL_HI = 2'd2;

    // where the inspector sends a packet
    typedef enum logic [1:0] {
        DEST_FP_THIS,
        DEST_FP_OTHER,
        DEST_SP_BOTH
    } dest_t;

endpackage

//--- hw/router_settings.sv
module router_settings
    import router_stream_pkg::*;
    import router_proto_pkg::*;
(
    input  logic                         stream_clk,
    input  logic                         rst_n_i,

    // one-cycle setting strobe
    input  logic                         set_stb_i,
    input  logic [$bits(CTRL_ADDR)-1:0]  set_addr_i,
    input  logic [DATA_W-1:0]            set_data_i,

    // ip address of this router
    output logic [DATA_W-1:0]            my_ip_o
);

    logic [DATA_W-1:0] my_ip_q;
    logic              ctrl_wr;
    logic [1:0]        ip_sel;

    assign ctrl_wr = set_stb_i && (set_addr_i == CTRL_ADDR);
    assign ip_sel  = set_data_i[5:4];

    // the new half-word always comes from the upper half of the control word
    always_ff @(posedge stream_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            my_ip_q <= '0;
        end else if (ctrl_wr) begin
            case (ip_sel)
                IP_SEL_LO: begin
                    my_ip_q[DATA_W/2-1:0] <= set_data_i[DATA_W-1:DATA_W/2];
                end
                IP_SEL_HI: begin
                    my_ip_q[DATA_W-1:DATA_W/2] <= set_data_i[DATA_W-1:DATA_W/2];
                end
                default: begin
                    // other control writes leave the ip alone
                end
            endcase
        end
    end

    assign my_ip_o = my_ip_q;

endmodule

//--- hw/router_stream_pkg.sv
package router_stream_pkg;

    ////////////////////////////////////////
    // stream line layout
    ////////////////////////////////////////

    // full line: 4 flag bits above a 32-bit payload word
    localparam int LINE_W = 36;

    // payload part of a line
    localparam int DATA_W = 32;

    // frame flag positions inside the flag nibble
    localparam int SOF_BIT = 32;
    localparam int EOF_BIT = 33;

    // bits 35 and 34 are spare and travel untouched,
    // except on the first DSP line where the inspector rewrites the flags

    ////////////////////////////////////////
    // line type
    ////////////////////////////////////////

    // one stream line as carried on every data port of the router
    typedef logic [LINE_W-1:0] line_t;

endpackage

//--- hw/stream_mux.sv
module stream_mux
    import router_stream_pkg::*;
(
    input  logic  stream_clk,
    input  logic  rst_n_i,

    input  line_t in0_data_i,
    input  logic  in0_valid_i,
    output logic  in0_ready_o,

    input  line_t in1_data_i,
    input  logic  in1_valid_i,
    output logic  in1_ready_o,

    output line_t out_data_o,
    output logic  out_valid_o,
    input  logic  out_ready_i
);

    logic locked_q;
    logic sel_q;
    logic prio_q;
    logic grant;
    logic cur_sel;
    logic out_xfer;

    ////////////////////////////////////////
    // input selection
    ////////////////////////////////////////

    // prio_q names the input that wins when both are waiting
    always_comb begin
        if (in0_valid_i && in1_valid_i) begin
            grant = prio_q;
        end else begin
            grant = in1_valid_i;
        end
    end

    assign cur_sel = locked_q ? sel_q : grant;

    assign out_data_o  = cur_sel ? in1_data_i : in0_data_i;
    assign out_valid_o = cur_sel ? in1_valid_i : in0_valid_i;
    assign in0_ready_o = out_ready_i && !cur_sel;
    assign in1_ready_o = out_ready_i && cur_sel;
    assign out_xfer    = out_valid_o && out_ready_i;

    ////////////////////////////////////////
    // packet lock
    ////////////////////////////////////////

    // lock as soon as a line is offered so the output stays stable
    // while it waits for ready
    always_ff @(posedge stream_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            locked_q <= 1'b0;
            sel_q    <= 1'b0;
            prio_q   <= 1'b0;
        end else if (out_xfer && out_data_o[EOF_BIT]) begin
            locked_q <= 1'b0;
            prio_q   <= !cur_sel;
        end else if (out_valid_o) begin
            locked_q <= 1'b1;
            sel_q    <= cur_sel;
        end
    end

endmodule

//--- hw/stream_splitter.sv
module stream_splitter
    import router_stream_pkg::*;
(
    input  logic  stream_clk,
    input  logic  rst_n_i,

    input  line_t inp_data_i,
    input  logic  inp_valid_i,
    output logic  inp_ready_o,

    output line_t out0_data_o,
    output logic  out0_valid_o,
    input  logic  out0_ready_i,

    output line_t out1_data_o,
    output logic  out1_valid_o,
    input  logic  out1_ready_i
);

    // both copies load on the same edge, so one data word serves them;
    // each output keeps its own full flag and drains on its own
    line_t      hold_q;
    logic [1:0] full_q;
    logic       accept;

    assign inp_ready_o = (full_q == 2'b00);
    assign accept      = inp_valid_i && inp_ready_o;

    always_ff @(posedge stream_clk) begin
        if (accept) begin
            hold_q <= inp_data_i;
        end
    end

    always_ff @(posedge stream_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 2'b00;
        end else if (accept) begin
            full_q <= 2'b11;
        end else begin
            if (out0_valid_o && out0_ready_i) begin
                full_q[0] <= 1'b0;
            end
            if (out1_valid_o && out1_ready_i) begin
                full_q[1] <= 1'b0;
            end
        end
    end

    assign out0_data_o  = hold_q;
    assign out0_valid_o = full_q[0];
    assign out1_data_o  = hold_q;
    assign out1_valid_o = full_q[1];

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_packet_router -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_packet_router)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

//--- sim.f
+incdir+dv
hw/router_stream_pkg.sv
hw/router_proto_pkg.sv
hw/router_settings.sv
hw/com_inspector.sv
hw/stream_splitter.sv
hw/stream_mux.sv
hw/packet_router_top.sv
dv/tb_packet_router.sv
